// ==== rvv_div_pkg.sv ====
`default_nettype none

package rvv_div_pkg;

  // vector and scalar widths
  localparam int vlen_default    = 64;
  localparam int xlen            = 32;
  localparam int rob_depth_width = 4;

  // element payloads of the divider lanes
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] hword_t;
  typedef logic [31:0] word_t;

  typedef logic [rob_depth_width-1:0] rob_tag_t;
  typedef logic [xlen-1:0]            xlen_t;

  typedef enum logic [1:0] {
    eew8  = 2'd0,
    eew16 = 2'd1,
    eew32 = 2'd2
  } eew_e;

  // integer multiply/divide major codes
  localparam logic [2:0] funct3_opmvv = 3'b010;
  localparam logic [2:0] funct3_opmvx = 3'b110;

  localparam logic [5:0] funct6_vdivu = 6'b100000;
  localparam logic [5:0] funct6_vdiv  = 6'b100001;
  localparam logic [5:0] funct6_vremu = 6'b100010;
  localparam logic [5:0] funct6_vrem  = 6'b100011;

endpackage

`default_nettype wire

// ==== div_lane_if.sv ====
`default_nettype none

interface div_lane_if #(
  parameter type lane_t = logic [7:0],
  parameter int  lanes  = 1
);

  logic              start;
  logic              is_signed;
  lane_t [lanes-1:0] dividend;
  lane_t [lanes-1:0] divisor;
  // all lanes of the bank finished
  logic              done;
  lane_t [lanes-1:0] quotient;
  lane_t [lanes-1:0] remainder;
  logic              ack;
  logic              flush;

  modport issue (
    output start, is_signed, dividend, divisor, ack, flush,
    input  done, quotient, remainder
  );

  modport bank (
    input  start, is_signed, dividend, divisor, ack, flush,
    output done, quotient, remainder
  );

endinterface

`default_nettype wire

// ==== div_lane.sv ====
`default_nettype none

module div_lane #(
  parameter type lane_t = logic [7:0]
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        start,
  input  wire        is_signed,
  input  wire lane_t dividend,
  input  wire lane_t divisor,
  input  wire        ack,
  input  wire        flush,
  output logic       done,
  output lane_t      quotient,
  output lane_t      remainder
);

  localparam int w     = $bits(lane_t);
  localparam int cnt_w = $clog2(w + 1);

  logic             busy;
  logic [cnt_w-1:0] cnt;
  lane_t            quo_q;
  lane_t            rem_q;
  lane_t            dvs_q;
  logic             neg_q;
  logic             neg_r;
  lane_t            a_mag;
  lane_t            b_mag;
  logic [w:0]       rem_shift;
  logic [w:0]       diff;

  // operand magnitudes and one trial subtract
  always_comb begin
    a_mag     = (is_signed && dividend[w-1]) ? lane_t'(-dividend) : dividend;
    b_mag     = (is_signed && divisor[w-1]) ? lane_t'(-divisor) : divisor;
    rem_shift = {rem_q, quo_q[w-1]};
    diff      = rem_shift - {1'b0, dvs_q};
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      done <= 1'b0;
      cnt  <= '0;
    end else if (flush) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else if (start) begin
      busy <= 1'b1;
      done <= 1'b0;
      cnt  <= cnt_w'(w);
    end else if (busy) begin
      cnt <= cnt - 1'b1;
      // done lands together with the last quotient bit
      if (cnt == cnt_w'(1)) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end else if (ack) begin
      done <= 1'b0;
    end
  end

  // quo_q starts as the dividend and fills with quotient bits from the right
  always_ff @(posedge clk) begin
    if (start) begin
      quo_q <= a_mag;
      rem_q <= '0;
      dvs_q <= b_mag;
      // a zero divisor keeps the all-ones quotient unsigned
      neg_q <= is_signed & (dividend[w-1] ^ divisor[w-1]) & (|divisor);
      neg_r <= is_signed & dividend[w-1];
    end else if (busy) begin
      if (!diff[w]) begin
        rem_q <= diff[w-1:0];
        quo_q <= {quo_q[w-2:0], 1'b1};
      end else begin
        rem_q <= rem_shift[w-1:0];
        quo_q <= {quo_q[w-2:0], 1'b0};
      end
    end
  end

  // sign fixup; min / -1 wraps back to the dividend by itself
  assign quotient  = neg_q ? lane_t'(-quo_q) : quo_q;
  assign remainder = neg_r ? lane_t'(-rem_q) : rem_q;

endmodule

`default_nettype wire

// ==== div_lane_bank.sv ====
`default_nettype none

module div_lane_bank #(
  parameter type lane_t = logic [7:0],
  parameter int  lanes  = 1
) (
  input wire       clk,
  input wire       rst_n,
  div_lane_if.bank bank
);

  logic [lanes-1:0] lane_done;

  for (genvar i = 0; i < lanes; i++) begin : g_lane
    div_lane #(
      .lane_t (lane_t)
    ) u_lane (
      .clk       (clk),
      .rst_n     (rst_n),
      .start     (bank.start),
      .is_signed (bank.is_signed),
      .dividend  (bank.dividend[i]),
      .divisor   (bank.divisor[i]),
      .ack       (bank.ack),
      .flush     (bank.flush),
      .done      (lane_done[i]),
      .quotient  (bank.quotient[i]),
      .remainder (bank.remainder[i])
    );
  end

  // bank is done once every lane is
  assign bank.done = &lane_done;

endmodule

`default_nettype wire

// ==== div_operand_split.sv ====
`default_nettype none

module div_operand_split #(
  parameter int VLEN = 64
) (
  input wire rvv_div_pkg::eew_e eew,
  input wire                    is_signed,
  input wire                    use_scalar,
  input wire [VLEN-1:0]         src1,
  input wire [VLEN-1:0]         src2,
  div_lane_if.issue             bank8,
  div_lane_if.issue             bank16,
  div_lane_if.issue             bank32
);

  localparam int n8  = VLEN / 8;
  localparam int n16 = VLEN / 16;
  localparam int n32 = VLEN / 32;

  logic [VLEN-1:0] op1;

  function automatic rvv_div_pkg::hword_t ext8_16(input rvv_div_pkg::byte_t e, input logic s);
    return {{8{s & e[7]}}, e};
  endfunction

  function automatic rvv_div_pkg::word_t ext8_32(input rvv_div_pkg::byte_t e, input logic s);
    return {{24{s & e[7]}}, e};
  endfunction

  function automatic rvv_div_pkg::word_t ext16_32(input rvv_div_pkg::hword_t e, input logic s);
    return {{16{s & e[15]}}, e};
  endfunction

  // .vx repeats the low element of rs1 over the whole vector
  always_comb begin
    op1 = src1;
    if (use_scalar) begin
      case (eew)
        rvv_div_pkg::eew8:  op1 = {n8{src1[7:0]}};
        rvv_div_pkg::eew16: op1 = {n16{src1[15:0]}};
        default:            op1 = {n32{src1[31:0]}};
      endcase
    end
  end

  // low half in own-width lanes, the rest spills upward
  always_comb begin
    bank8.dividend  = '0;
    bank8.divisor   = '0;
    bank16.dividend = '0;
    bank16.divisor  = '0;
    bank32.dividend = '0;
    bank32.divisor  = '0;
    case (eew)
      rvv_div_pkg::eew8: begin
        for (int i = 0; i < n8 / 2; i++) begin
          bank8.dividend[i] = src2[i*8 +: 8];
          bank8.divisor[i]  = op1[i*8 +: 8];
        end
        for (int i = 0; i < n8 / 4; i++) begin
          bank16.dividend[i] = ext8_16(src2[(n8/2+i)*8 +: 8], is_signed);
          bank16.divisor[i]  = ext8_16(op1[(n8/2+i)*8 +: 8], is_signed);
          bank32.dividend[i] = ext8_32(src2[(n8*3/4+i)*8 +: 8], is_signed);
          bank32.divisor[i]  = ext8_32(op1[(n8*3/4+i)*8 +: 8], is_signed);
        end
      end
      rvv_div_pkg::eew16: begin
        for (int i = 0; i < n16 / 2; i++) begin
          bank16.dividend[i] = src2[i*16 +: 16];
          bank16.divisor[i]  = op1[i*16 +: 16];
          bank32.dividend[i] = ext16_32(src2[(n16/2+i)*16 +: 16], is_signed);
          bank32.divisor[i]  = ext16_32(op1[(n16/2+i)*16 +: 16], is_signed);
        end
      end
      rvv_div_pkg::eew32: begin
        for (int i = 0; i < n32; i++) begin
          bank32.dividend[i] = src2[i*32 +: 32];
          bank32.divisor[i]  = op1[i*32 +: 32];
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== div_result_merge.sv ====
`default_nettype none

module div_result_merge #(
  parameter int VLEN = 64
) (
  input  wire rvv_div_pkg::eew_e eew,
  input  wire                    is_rem,
  div_lane_if.issue              bank8,
  div_lane_if.issue              bank16,
  div_lane_if.issue              bank32,
  output logic [VLEN-1:0]        result_data
);

  localparam int n8  = VLEN / 8;
  localparam int n16 = VLEN / 16;
  localparam int n32 = VLEN / 32;

  rvv_div_pkg::byte_t  [n8/2-1:0]  r8;
  rvv_div_pkg::hword_t [n16/2-1:0] r16;
  rvv_div_pkg::word_t  [n32-1:0]   r32;

  assign r8  = is_rem ? bank8.remainder : bank8.quotient;
  assign r16 = is_rem ? bank16.remainder : bank16.quotient;
  assign r32 = is_rem ? bank32.remainder : bank32.quotient;

  // inverse of the split layout, spilled results cut back to eew
  always_comb begin
    result_data = '0;
    case (eew)
      rvv_div_pkg::eew8: begin
        for (int i = 0; i < n8 / 2; i++) begin
          result_data[i*8 +: 8] = r8[i];
        end
        for (int i = 0; i < n8 / 4; i++) begin
          result_data[(n8/2+i)*8 +: 8]   = r16[i][7:0];
          result_data[(n8*3/4+i)*8 +: 8] = r32[i][7:0];
        end
      end
      rvv_div_pkg::eew16: begin
        for (int i = 0; i < n16 / 2; i++) begin
          result_data[i*16 +: 16]         = r16[i];
          result_data[(n16/2+i)*16 +: 16] = r32[i][15:0];
        end
      end
      rvv_div_pkg::eew32: begin
        for (int i = 0; i < n32; i++) begin
          result_data[i*32 +: 32] = r32[i];
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== div_uop_ctrl.sv ====
`default_nettype none

module div_uop_ctrl #(
  parameter int VLEN = 64
) (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        uop_valid,
  input  wire [5:0]                  funct6,
  input  wire [2:0]                  funct3,
  input  wire rvv_div_pkg::eew_e     vs2_eew,
  input  wire [VLEN-1:0]             vs1_data,
  input  wire [VLEN-1:0]             vs2_data,
  input  wire rvv_div_pkg::xlen_t    rs1_data,
  input  wire rvv_div_pkg::rob_tag_t rob_entry,
  input  wire                        result_ready,
  input  wire                        trap_flush,
  output logic                       uop_ready,
  output logic                       result_valid,
  output rvv_div_pkg::rob_tag_t      result_rob_entry,
  output rvv_div_pkg::eew_e          eew,
  output logic                       is_rem,
  output logic                       use_scalar,
  output logic [VLEN-1:0]            src1,
  output logic [VLEN-1:0]            src2,
  div_lane_if.issue                  bank8,
  div_lane_if.issue                  bank16,
  div_lane_if.issue                  bank32
);

  typedef enum logic [1:0] {
    st_idle,
    st_busy,
    st_done
  } state_e;

  state_e state;
  logic   legal;
  logic   accept;
  logic   is_signed;
  logic   start_q;
  logic   all_done;

  always_comb begin
    legal = 1'b0;
    if (funct3 == rvv_div_pkg::funct3_opmvv || funct3 == rvv_div_pkg::funct3_opmvx) begin
      case (funct6)
        rvv_div_pkg::funct6_vdivu,
        rvv_div_pkg::funct6_vdiv,
        rvv_div_pkg::funct6_vremu,
        rvv_div_pkg::funct6_vrem: legal = 1'b1;
        default: legal = 1'b0;
      endcase
    end
  end

  // illegal ops are taken and dropped here
  assign uop_ready    = (state == st_idle);
  assign accept       = uop_valid & uop_ready & legal & ~trap_flush;
  assign result_valid = (state == st_done);

  // narrower banks only take part for narrower eew
  assign all_done = bank32.done &
                    ((eew == rvv_div_pkg::eew32) || bank16.done) &
                    ((eew != rvv_div_pkg::eew8) || bank8.done);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= st_idle;
      start_q <= 1'b0;
    end else if (trap_flush) begin
      state   <= st_idle;
      start_q <= 1'b0;
    end else begin
      start_q <= accept;
      case (state)
        st_idle: if (accept) state <= st_busy;
        st_busy: if (all_done) state <= st_done;
        st_done: if (result_ready) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      eew              <= vs2_eew;
      is_rem           <= (funct6 == rvv_div_pkg::funct6_vremu) ||
                          (funct6 == rvv_div_pkg::funct6_vrem);
      is_signed        <= (funct6 == rvv_div_pkg::funct6_vdiv) ||
                          (funct6 == rvv_div_pkg::funct6_vrem);
      use_scalar       <= (funct3 == rvv_div_pkg::funct3_opmvx);
      src1             <= (funct3 == rvv_div_pkg::funct3_opmvx) ? VLEN'(rs1_data) : vs1_data;
      src2             <= vs2_data;
      result_rob_entry <= rob_entry;
    end
  end

  assign bank8.start  = start_q & (eew == rvv_div_pkg::eew8);
  assign bank16.start = start_q & (eew != rvv_div_pkg::eew32);
  assign bank32.start = start_q;

  assign bank8.is_signed  = is_signed;
  assign bank16.is_signed = is_signed;
  assign bank32.is_signed = is_signed;

  // ack on the result handshake
  assign bank8.ack  = result_valid & result_ready;
  assign bank16.ack = result_valid & result_ready;
  assign bank32.ack = result_valid & result_ready;

  assign bank8.flush  = trap_flush;
  assign bank16.flush = trap_flush;
  assign bank32.flush = trap_flush;

endmodule

`default_nettype wire

// ==== rvv_div_unit.sv ====
`default_nettype none

module rvv_div_unit #(
  parameter int VLEN = rvv_div_pkg::vlen_default
) (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        uop_valid,
  input  wire [5:0]                  funct6,
  input  wire [2:0]                  funct3,
  input  wire rvv_div_pkg::eew_e     vs2_eew,
  input  wire [VLEN-1:0]             vs1_data,
  input  wire [VLEN-1:0]             vs2_data,
  input  wire rvv_div_pkg::xlen_t    rs1_data,
  input  wire rvv_div_pkg::rob_tag_t rob_entry,
  input  wire                        result_ready,
  input  wire                        trap_flush,
  output logic                       uop_ready,
  output logic                       result_valid,
  output logic [VLEN-1:0]            result_data,
  output rvv_div_pkg::rob_tag_t      result_rob_entry
);

  // byte lanes hold half the bytes, the other banks a quarter each
  localparam int lanes8  = VLEN / 16;
  localparam int lanes16 = VLEN / 32;
  localparam int lanes32 = VLEN / 32;

  rvv_div_pkg::eew_e eew;
  logic              is_rem;
  logic              use_scalar;
  logic [VLEN-1:0]   src1;
  logic [VLEN-1:0]   src2;

  div_lane_if #(.lane_t(rvv_div_pkg::byte_t),  .lanes(lanes8))  bank8_if ();
  div_lane_if #(.lane_t(rvv_div_pkg::hword_t), .lanes(lanes16)) bank16_if ();
  div_lane_if #(.lane_t(rvv_div_pkg::word_t),  .lanes(lanes32)) bank32_if ();

  div_uop_ctrl #(
    .VLEN (VLEN)
  ) u_ctrl (
    .clk              (clk),
    .rst_n            (rst_n),
    .uop_valid        (uop_valid),
    .funct6           (funct6),
    .funct3           (funct3),
    .vs2_eew          (vs2_eew),
    .vs1_data         (vs1_data),
    .vs2_data         (vs2_data),
    .rs1_data         (rs1_data),
    .rob_entry        (rob_entry),
    .result_ready     (result_ready),
    .trap_flush       (trap_flush),
    .uop_ready        (uop_ready),
    .result_valid     (result_valid),
    .result_rob_entry (result_rob_entry),
    .eew              (eew),
    .is_rem           (is_rem),
    .use_scalar       (use_scalar),
    .src1             (src1),
    .src2             (src2),
    .bank8            (bank8_if),
    .bank16           (bank16_if),
    .bank32           (bank32_if)
  );

  div_operand_split #(
    .VLEN (VLEN)
  ) u_split (
    .eew        (eew),
    .is_signed  (bank32_if.is_signed),
    .use_scalar (use_scalar),
    .src1       (src1),
    .src2       (src2),
    .bank8      (bank8_if),
    .bank16     (bank16_if),
    .bank32     (bank32_if)
  );

  div_lane_bank #(.lane_t(rvv_div_pkg::byte_t), .lanes(lanes8)) u_bank8 (
    .clk   (clk),
    .rst_n (rst_n),
    .bank  (bank8_if)
  );

  div_lane_bank #(.lane_t(rvv_div_pkg::hword_t), .lanes(lanes16)) u_bank16 (
    .clk   (clk),
    .rst_n (rst_n),
    .bank  (bank16_if)
  );

  div_lane_bank #(.lane_t(rvv_div_pkg::word_t), .lanes(lanes32)) u_bank32 (
    .clk   (clk),
    .rst_n (rst_n),
    .bank  (bank32_if)
  );

  div_result_merge #(
    .VLEN (VLEN)
  ) u_merge (
    .eew         (eew),
    .is_rem      (is_rem),
    .bank8       (bank8_if),
    .bank16      (bank16_if),
    .bank32      (bank32_if),
    .result_data (result_data)
  );

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`default_nettype none

module tb_clk_gen #(
  parameter int period       = 8,
  parameter int reset_cycles = 2
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // release just after an edge
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb_rvv_div.sv ====
`default_nettype none

module tb_rvv_div;

  localparam int vlen    = rvv_div_pkg::vlen_default;
  localparam int t_limit = 100;

  logic                  clk;
  logic                  rst_n;
  logic                  uop_valid;
  logic [5:0]            funct6;
  logic [2:0]            funct3;
  rvv_div_pkg::eew_e     vs2_eew;
  logic [vlen-1:0]       vs1_data;
  logic [vlen-1:0]       vs2_data;
  rvv_div_pkg::xlen_t    rs1_data;
  rvv_div_pkg::rob_tag_t rob_entry;
  logic                  result_ready;
  logic                  trap_flush;
  logic                  uop_ready;
  logic                  result_valid;
  logic [vlen-1:0]       result_data;
  rvv_div_pkg::rob_tag_t result_rob_entry;

  logic [31:0]           lfsr;
  int                    n_errors;
  int                    n_checks;
  rvv_div_pkg::rob_tag_t next_tag;
  logic [vlen-1:0]       exp_data_q[$];
  rvv_div_pkg::rob_tag_t exp_rob_q[$];

  tb_clk_gen #(.period(8), .reset_cycles(2)) u_clk (.clk(clk), .rst_n(rst_n));

  rvv_div_unit #(
    .VLEN (vlen)
  ) u_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .uop_valid        (uop_valid),
    .funct6           (funct6),
    .funct3           (funct3),
    .vs2_eew          (vs2_eew),
    .vs1_data         (vs1_data),
    .vs2_data         (vs2_data),
    .rs1_data         (rs1_data),
    .rob_entry        (rob_entry),
    .result_ready     (result_ready),
    .trap_flush       (trap_flush),
    .uop_ready        (uop_ready),
    .result_valid     (result_valid),
    .result_data      (result_data),
    .result_rob_entry (result_rob_entry)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  // one lfsr step per bit
  task automatic rand_bits(input int n, output logic [vlen-1:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
  endtask

  function automatic logic [5:0] funct_of(input int k);
    case (k % 4)
      0:       return rvv_div_pkg::funct6_vdivu;
      1:       return rvv_div_pkg::funct6_vremu;
      2:       return rvv_div_pkg::funct6_vdiv;
      default: return rvv_div_pkg::funct6_vrem;
    endcase
  endfunction

  function automatic logic [vlen-1:0] sign_mask(input rvv_div_pkg::eew_e eew);
    case (eew)
      rvv_div_pkg::eew8:  return {(vlen / 8){8'h80}};
      rvv_div_pkg::eew16: return {(vlen / 16){16'h8000}};
      default:            return {(vlen / 32){32'h8000_0000}};
    endcase
  endfunction

  function automatic longint elem_value(input logic [vlen-1:0] v, input int idx, input int w,
                                        input logic sgn);
    longint x;
    x = longint'((v >> (idx * w)) & ((64'd1 << w) - 1));
    if (sgn && x[w-1]) begin
      x = x - (longint'(1) << w);
    end
    return x;
  endfunction

  // element by element, independent of the lane layout
  function automatic logic [vlen-1:0] ref_div(input logic [5:0] f6, input logic [2:0] f3,
                                              input rvv_div_pkg::eew_e eew,
                                              input logic [vlen-1:0] v1,
                                              input logic [vlen-1:0] v2,
                                              input rvv_div_pkg::xlen_t r1);
    int              w;
    logic            sgn;
    logic            rem;
    longint          a;
    longint          b;
    longint          q;
    longint          r;
    logic [vlen-1:0] res;
    w   = (eew == rvv_div_pkg::eew8) ? 8 : (eew == rvv_div_pkg::eew16) ? 16 : 32;
    sgn = (f6 == rvv_div_pkg::funct6_vdiv) || (f6 == rvv_div_pkg::funct6_vrem);
    rem = (f6 == rvv_div_pkg::funct6_vremu) || (f6 == rvv_div_pkg::funct6_vrem);
    res = '0;
    for (int i = 0; i < vlen / w; i++) begin
      a = elem_value(v2, i, w, sgn);
      if (f3 == rvv_div_pkg::funct3_opmvx) begin
        b = elem_value(vlen'(r1), 0, w, sgn);
      end else begin
        b = elem_value(v1, i, w, sgn);
      end
      if (b == 0) begin
        q = -1;
        r = a;
      end else if (sgn && b == -1 && a == -(longint'(1) << (w - 1))) begin
        q = a;
        r = 0;
      end else begin
        q = a / b;
        r = a % b;
      end
      res = res | ((vlen'(rem ? r : q) & ((64'd1 << w) - 1)) << (i * w));
    end
    return res;
  endfunction

  task automatic check_data(input string name, input logic [vlen-1:0] got,
                            input logic [vlen-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERROR at %0t: %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_rob(input string name, input rvv_div_pkg::rob_tag_t got,
                           input rvv_div_pkg::rob_tag_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERROR at %0t: %s got %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERROR at %0t: %s got %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s at %0t", why, $time);
    $display("Test failures found");
    $finish;
  endtask

  // every transfer against the oldest expected result
  always @(negedge clk) begin
    if (rst_n && result_valid && result_ready) begin
      if (exp_data_q.size() == 0) begin
        n_errors++;
        $display("a result came out with no op pending at %0t, tag %0d",
                 $time, result_rob_entry);
      end else begin
        check_data("result_data", result_data, exp_data_q.pop_front());
        check_rob("result_rob_entry", result_rob_entry, exp_rob_q.pop_front());
      end
    end
  end

  task automatic issue_op(input logic [5:0] f6, input logic [2:0] f3,
                          input rvv_div_pkg::eew_e eew, input logic [vlen-1:0] v1,
                          input logic [vlen-1:0] v2, input rvv_div_pkg::xlen_t r1,
                          input logic legal);
    int waited;
    waited    = 0;
    uop_valid = 1'b1;
    funct6    = f6;
    funct3    = f3;
    vs2_eew   = eew;
    vs1_data  = v1;
    vs2_data  = v2;
    rs1_data  = r1;
    rob_entry = next_tag;
    while (!uop_ready && waited < t_limit) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!uop_ready) begin
      abort_run("uop_ready never came back");
    end else begin
      if (legal) begin
        exp_data_q.push_back(ref_div(f6, f3, eew, v1, v2, r1));
        exp_rob_q.push_back(next_tag);
      end
      @(posedge clk);
      #1;
      uop_valid = 1'b0;
      next_tag++;
    end
  endtask

  task automatic wait_transfer();
    int waited;
    waited = 0;
    while (!(result_valid && result_ready) && waited < t_limit) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!(result_valid && result_ready)) begin
      abort_run("no result transfer within the timeout");
    end else begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic run_op(input logic [5:0] f6, input logic [2:0] f3,
                        input rvv_div_pkg::eew_e eew, input logic [vlen-1:0] v1,
                        input logic [vlen-1:0] v2, input rvv_div_pkg::xlen_t r1);
    issue_op(f6, f3, eew, v1, v2, r1, 1'b1);
    wait_transfer();
  endtask

  task automatic idle_window(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #1;
    end
  endtask

  // kind 0 unsigned vv, 1 signed vv with negative dividends, 2 vx over all four ops
  // rem ops in kind 2 get a scalar with its element sign bit set
  task automatic random_ops(input int kind);
    logic [vlen-1:0]   a;
    logic [vlen-1:0]   b;
    logic [vlen-1:0]   s;
    rvv_div_pkg::eew_e e;
    for (int ei = 0; ei < 3; ei++) begin
      e = rvv_div_pkg::eew_e'(ei);
      for (int k = 0; k < 4; k++) begin
        rand_bits(vlen, a);
        rand_bits(vlen, b);
        rand_bits(32, s);
        if (kind == 0) begin
          run_op(funct_of(k % 2), rvv_div_pkg::funct3_opmvv, e, b, a, '0);
        end else if (kind == 1) begin
          run_op(funct_of(2 + k % 2), rvv_div_pkg::funct3_opmvv, e,
                 (k < 2) ? b : (b | sign_mask(e)), a | sign_mask(e), '0);
        end else begin
          if (k % 2 == 1) begin
            s = s | sign_mask(e);
          end
          run_op(funct_of(k), rvv_div_pkg::funct3_opmvx, e, b, a, s[31:0]);
        end
      end
    end
  endtask

  task automatic corner_ops();
    logic [vlen-1:0] a;
    for (int ei = 0; ei < 3; ei++) begin
      for (int k = 0; k < 4; k++) begin
        rand_bits(vlen, a);
        run_op(funct_of(k), rvv_div_pkg::funct3_opmvv, rvv_div_pkg::eew_e'(ei), '0, a, '0);
        run_op(funct_of(k), rvv_div_pkg::funct3_opmvv, rvv_div_pkg::eew_e'(ei), '1,
               sign_mask(rvv_div_pkg::eew_e'(ei)), '0);
      end
    end
  endtask

  task automatic backpressure_hold();
    logic [vlen-1:0]       a;
    logic [vlen-1:0]       b;
    logic [vlen-1:0]       hold;
    logic [vlen-1:0]       held_data;
    rvv_div_pkg::rob_tag_t held_rob;
    int                    waited;
    rand_bits(vlen, a);
    rand_bits(vlen, b);
    rand_bits(3, hold);
    result_ready = 1'b0;
    issue_op(rvv_div_pkg::funct6_vdiv, rvv_div_pkg::funct3_opmvv, rvv_div_pkg::eew16,
             b, a | sign_mask(rvv_div_pkg::eew16), '0, 1'b1);
    waited = 0;
    while (!result_valid && waited < t_limit) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!result_valid) begin
      abort_run("result_valid never rose under back-pressure");
    end else begin
      held_data = result_data;
      held_rob  = result_rob_entry;
      for (int i = 0; i < int'(hold) + 2; i++) begin
        @(posedge clk);
        #1;
        check_flag("result_valid", result_valid, 1'b1);
        check_flag("uop_ready", uop_ready, 1'b0);
        check_data("result_data", result_data, held_data);
        check_rob("result_rob_entry", result_rob_entry, held_rob);
      end
      result_ready = 1'b1;
      wait_transfer();
      check_flag("result_valid", result_valid, 1'b0);
      check_flag("uop_ready", uop_ready, 1'b1);
    end
  endtask

  task automatic flush_and_illegal();
    logic [vlen-1:0] a;
    logic [vlen-1:0] b;
    rand_bits(vlen, a);
    rand_bits(vlen, b);
    issue_op(rvv_div_pkg::funct6_vdivu, rvv_div_pkg::funct3_opmvv, rvv_div_pkg::eew32,
             b, a, '0, 1'b0);
    idle_window(5);
    trap_flush = 1'b1;
    idle_window(1);
    trap_flush = 1'b0;
    check_flag("result_valid", result_valid, 1'b0);
    check_flag("uop_ready", uop_ready, 1'b1);
    idle_window(40);
    // vmulhu encoding, not a divide
    issue_op(6'b100100, rvv_div_pkg::funct3_opmvv, rvv_div_pkg::eew8, b, a, '0, 1'b0);
    check_flag("uop_ready", uop_ready, 1'b1);
    idle_window(40);
    run_op(rvv_div_pkg::funct6_vrem, rvv_div_pkg::funct3_opmvx, rvv_div_pkg::eew8,
           b, a, 32'hFFFF_FFF9);
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("%-22s %s", name, (n_errors == errors_before) ? "ok" : "FAILED");
  endtask

  initial begin
    int mark;
    int waited;
    lfsr         = 32'd18;
    n_errors     = 0;
    n_checks     = 0;
    next_tag     = '0;
    uop_valid    = 1'b0;
    funct6       = '0;
    funct3       = '0;
    vs2_eew      = rvv_div_pkg::eew8;
    vs1_data     = '0;
    vs2_data     = '0;
    rs1_data     = '0;
    rob_entry    = '0;
    result_ready = 1'b1;
    trap_flush   = 1'b0;
    waited       = 0;
    while (rst_n !== 1'b1 && waited < t_limit) begin
      @(posedge clk);
      waited++;
    end
    @(posedge clk);
    #1;
    check_flag("uop_ready", uop_ready, 1'b1);
    check_flag("result_valid", result_valid, 1'b0);

    mark = n_errors;
    random_ops(0);
    report_test("unsigned vv", mark);
    mark = n_errors;
    random_ops(1);
    report_test("signed vv", mark);
    mark = n_errors;
    random_ops(2);
    report_test("scalar vx", mark);
    mark = n_errors;
    corner_ops();
    report_test("zero and overflow", mark);
    mark = n_errors;
    backpressure_hold();
    report_test("back-pressure", mark);
    mark = n_errors;
    flush_and_illegal();
    report_test("flush and illegal op", mark);

    idle_window(2);
    if (exp_data_q.size() != 0) begin
      n_errors++;
      $display("%0d expected results never came out", exp_data_q.size());
    end
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rvv_div.f ====
rvv_div_pkg.sv
div_lane_if.sv
div_lane.sv
div_lane_bank.sv
div_operand_split.sv
div_result_merge.sv
div_uop_ctrl.sv
rvv_div_unit.sv
tb_clk_gen.sv
tb_rvv_div.sv
